// ==== project.f ====
rtl/mpa_core_pkg.sv
rtl/mips_isa_pkg.sv
rtl/mpa_fetch.sv
rtl/mpa_decoder.sv
rtl/mpa_regfile.sv
rtl/mpa_load_unit.sv
rtl/mpa_mips_top.sv
testbench/mpa_mips_assert.sv
testbench/tb_mpa_mips.sv

// ==== Bender.yml ====
package:
  name: mpa_mips

sources:
  - rtl/mpa_core_pkg.sv
  - rtl/mips_isa_pkg.sv
  - rtl/mpa_fetch.sv
  - rtl/mpa_decoder.sv
  - rtl/mpa_regfile.sv
  - rtl/mpa_load_unit.sv
  - rtl/mpa_mips_top.sv
  - target: simulation
    files:
      - testbench/mpa_mips_assert.sv
      - testbench/tb_mpa_mips.sv

// ==== testbench/tb_mpa_mips.sv ====
/* MIPS core testbench
   Directed back-door, LUI, load, no-op and restart tests with a summary */
module tb_mpa_mips;
    timeunit 1ns;
    timeprecision 100ps;
    import mpa_core_pkg::*;
    import mips_isa_pkg::*;

    localparam int max_run  = 64;     // Longest program window in cycles
    localparam int watchdog = 20000;  // Whole run, in cycles

    logic     mem_debug_clk_gate;
    logic     HW_RSTn;
    dbg_req_t dbg;
    word_t    dout;
    word_t    dm_model [dm_depth];    // Expected DM contents
    word_t    reg_model [num_regs];   // Expected register contents
    word_t    prog_q [$];             // Program being assembled
    int       errors;
    int       checks;
    int       tests;

    mpa_mips_top dut0 (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .dbg                (dbg),
        .dout               (dout)
    );

    always #4 mem_debug_clk_gate = ~mem_debug_clk_gate;  // 8 ns period

    task automatic step_clock();
        @(posedge mem_debug_clk_gate);
        #1;  // Drive point after the edge
    endtask

    function automatic word_t encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic write_backdoor(input debug_func_e func, input word_t addr, input word_t data);
        dbg.mem_debug = 1'b1;
        dbg.func      = func;
        dbg.addr      = addr;
        dbg.din       = data;
        dbg.we        = 1'b1;
        step_clock();
        dbg.we = 1'b0;
        if (func == dbg_dm) begin
            dm_model[addr[6:2]] = data;  // Word index, byte offset dropped
        end else if (func == dbg_mr && addr[4:0] != 5'd0) begin
            reg_model[addr[4:0]] = data;  // r0 stays zero
        end
    endtask

    task automatic read_backdoor(input debug_func_e func, input word_t addr, output word_t data);
        dbg.we   = 1'b0;
        dbg.func = func;
        dbg.addr = addr;
        #2;
        data = dout;  // Combinational read-out, settled
        step_clock();
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input int idx, input word_t exp);
        word_t got;
        read_backdoor(dbg_mr, idx, got);
        check_word($sformatf("r%0d", idx), got, exp);
        reg_model[idx] = exp;  // Checked value is the expected state from here on
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        if (errors == err0) $display("%s: ok", name);
        else $display("%s: %0d mismatches", name, errors - err0);
    endtask

    // Program words first, SPECIAL no-ops after
    task automatic load_program();
        for (int i = 0; i < im_depth; i++) begin
            if (i < prog_q.size()) write_backdoor(dbg_im, i * 4, prog_q[i]);
            else write_backdoor(dbg_im, i * 4, '0);
        end
        prog_q.delete();
    endtask

    task automatic run_program(input int n);
        int cyc;
        cyc = 0;
        dbg.we        = 1'b0;
        dbg.mem_debug = 1'b0;  // Fetch from address 0 starts here
        while (cyc < n) begin
            step_clock();
            cyc++;
            if (cyc >= max_run) begin
                $display("Timeout: program window of %0d cycles is over the limit", n);
                errors++;
                break;
            end
        end
        dbg.mem_debug = 1'b1;
    endtask

    task automatic backdoor_access();
        int    err0;
        word_t val;
        word_t got;
        err0 = errors;
        for (int r = 0; r < num_regs; r++) check_reg(r, '0);  // Reset state
        for (int i = 0; i < 4; i++) begin
            val = $urandom();
            write_backdoor(dbg_im, i * 8 + 4, val);
            read_backdoor(dbg_im, i * 8 + 4, got);
            check_word("IM word", got, val);
            val = $urandom();
            write_backdoor(dbg_dm, i * 12 + 64, val);
            read_backdoor(dbg_dm, i * 12 + 64, got);
            check_word("DM word", got, val);
            val = $urandom();
            write_backdoor(dbg_mr, i * 7 + 3, val);
            check_reg(i * 7 + 3, val);
        end
        write_backdoor(dbg_mr, 0, 32'hffff_ffff);
        check_reg(0, '0);  // r0 hard-wired
        read_backdoor(dbg_none, 32'h8, got);
        check_word("dbg_none read-out", got, '0);
        finish_test("backdoor", err0);
    endtask

    task automatic lui_upper_half();
        int          err0;
        logic [15:0] imm2;
        err0 = errors;
        imm2 = $urandom();
        prog_q.push_back(encode_itype(op_lui, 5'd0, 5'd1, 16'hbeef));
        prog_q.push_back(encode_itype(op_lui, 5'd0, 5'd2, imm2));
        load_program();
        run_program(2);
        check_reg(1, 32'hbeef_0000);  // Untouched by second LUI
        check_reg(2, {imm2, 16'h0000});
        finish_test("lui", err0);
    endtask

    task automatic lw_offsets();
        int    err0;
        word_t base;
        word_t ea;
        err0 = errors;
        base = 32'h18;
        write_backdoor(dbg_mr, 3, base);
        write_backdoor(dbg_dm, 32'h10, $urandom());
        write_backdoor(dbg_dm, 32'h20, $urandom());
        write_backdoor(dbg_dm, 32'h24, $urandom());
        prog_q.push_back(encode_itype(op_lw, 5'd3, 5'd4, 16'h0008));
        prog_q.push_back(encode_itype(op_lw, 5'd3, 5'd5, 16'hfff8));  // Negative offset
        prog_q.push_back(encode_itype(op_lw, 5'd3, 5'd6, 16'h000e));  // Low bits set
        load_program();
        run_program(3);
        ea = base + 32'h0000_0008;
        check_reg(4, dm_model[ea[6:2]]);
        ea = base + 32'hffff_fff8;
        check_reg(5, dm_model[ea[6:2]]);
        ea = base + 32'h0000_000e;
        check_reg(6, dm_model[ea[6:2]]);
        finish_test("lw_addr", err0);
    endtask

    task automatic subword_extend();
        int    err0;
        word_t byte_neg;
        word_t half_neg;
        err0 = errors;
        byte_neg = ($urandom() | 32'h0000_0080) & 32'hffff_7fff;  // Byte sign only
        half_neg = ($urandom() | 32'h0000_8000) & 32'hffff_ff7f;  // Half sign only
        write_backdoor(dbg_dm, 32'h08, byte_neg);
        write_backdoor(dbg_dm, 32'h0c, half_neg);
        prog_q.push_back(encode_itype(op_lb, 5'd0, 5'd8, 16'h0008));
        prog_q.push_back(encode_itype(op_lbu, 5'd0, 5'd9, 16'h0008));
        prog_q.push_back(encode_itype(op_lh, 5'd0, 5'd10, 16'h0008));
        prog_q.push_back(encode_itype(op_lhu, 5'd0, 5'd11, 16'h0008));
        prog_q.push_back(encode_itype(op_lb, 5'd0, 5'd12, 16'h000c));
        prog_q.push_back(encode_itype(op_lbu, 5'd0, 5'd13, 16'h000c));
        prog_q.push_back(encode_itype(op_lh, 5'd0, 5'd14, 16'h000c));
        prog_q.push_back(encode_itype(op_lhu, 5'd0, 5'd15, 16'h000c));
        load_program();
        run_program(8);
        check_reg(8, {24'hffffff, byte_neg[7:0]});
        check_reg(9, {24'h000000, byte_neg[7:0]});
        check_reg(10, {16'h0000, byte_neg[15:0]});
        check_reg(11, {16'h0000, byte_neg[15:0]});
        check_reg(12, {24'h000000, half_neg[7:0]});
        check_reg(13, {24'h000000, half_neg[7:0]});
        check_reg(14, {16'hffff, half_neg[15:0]});
        check_reg(15, {16'h0000, half_neg[15:0]});
        finish_test("subword", err0);
    endtask

    task automatic unsupported_opcodes();
        int    err0;
        word_t got;
        err0 = errors;
        prog_q.push_back(encode_itype(6'h2b, 5'd0, 5'd1, 16'h0004));   // SW
        prog_q.push_back(encode_itype(6'h28, 5'd0, 5'd2, 16'h0010));   // SB
        prog_q.push_back({6'h00, 5'd2, 5'd3, 5'd1, 5'd0, 6'h20});      // ADD r1
        prog_q.push_back(encode_itype(6'h08, 5'd2, 5'd1, 16'h7fff));   // ADDI
        load_program();
        run_program(4);
        for (int r = 0; r < num_regs; r++) check_reg(r, reg_model[r]);
        for (int i = 0; i < dm_depth; i++) begin
            read_backdoor(dbg_dm, i * 4, got);
            check_word($sformatf("DM word %0d", i), got, dm_model[i]);
        end
        finish_test("unsupported", err0);
    endtask

    task automatic restart_after_debug();
        int    err0;
        word_t ea;
        err0 = errors;
        write_backdoor(dbg_dm, 32'h24, $urandom());
        prog_q.push_back(encode_itype(op_lui, 5'd0, 5'd16, 16'h0001));
        prog_q.push_back(encode_itype(op_lw, 5'd16, 5'd17, 16'h0024));
        load_program();
        run_program(1);  // Stop after the LUI
        write_backdoor(dbg_mr, 16, '0);
        write_backdoor(dbg_mr, 17, '0);
        ea = 32'h0001_0024;  // Wraps into the DM window
        for (int pass = 0; pass < 2; pass++) begin
            run_program(2);  // Restart from address 0
            check_reg(16, 32'h0001_0000);
            check_reg(17, dm_model[ea[6:2]]);
        end
        finish_test("debug_restart", err0);
    endtask

    initial begin
        void'($urandom(32'h7b01));
        mem_debug_clk_gate = 1'b0;
        HW_RSTn            = 1'b0;
        dbg                = '0;
        dbg.mem_debug      = 1'b1;  // Core parked until programs run
        errors             = 0;
        checks             = 0;
        tests              = 0;
        repeat (4) @(posedge mem_debug_clk_gate);
        #1;
        HW_RSTn = 1'b1;
        for (int i = 0; i < dm_depth; i++) begin
            write_backdoor(dbg_dm, i * 4, 32'hc0de_0000 | (i * 4));  // Address-tagged fill
        end
        backdoor_access();
        lui_upper_half();
        lw_offsets();
        subword_extend();
        unsupported_opcodes();
        restart_after_debug();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Hang guard
    initial begin
        repeat (watchdog) @(posedge mem_debug_clk_gate);
        $display("Timeout: run did not finish within %0d cycles", watchdog);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== testbench/mpa_mips_assert.sv ====
/* Fetch-stage PC checker
   Restart under debug, word stepping inside the IM window, alignment */
module mpa_mips_assert (
    input logic                   mem_debug_clk_gate,
    input logic                   HW_RSTn,
    input mpa_core_pkg::dbg_req_t dbg,
    input mpa_core_pkg::word_t    pc
);
    timeunit 1ns;
    timeprecision 100ps;
    import mpa_core_pkg::*;

    localparam int im_bytes = im_depth * 4;  // IM window in bytes

    // Back-door cycle sends PC home
    pc_restart: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        dbg.mem_debug |=> (pc == reset_pc))
        else $error("PC not at reset_pc one cycle after debug");

    // Normal run, one word per cycle, wraps at the IM end
    pc_step: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        !dbg.mem_debug |=> (pc == (($past(pc) + 32'd4) % im_bytes)))
        else $error("PC did not advance by one word");

    pc_aligned: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        pc[1:0] == 2'b00)
        else $error("PC lost word alignment");

endmodule

bind mpa_fetch mpa_mips_assert u_pc_assert (
    .mem_debug_clk_gate (mem_debug_clk_gate),
    .HW_RSTn            (HW_RSTn),
    .dbg                (dbg),
    .pc                 (pc)
);

// ==== rtl/mpa_mips_top.sv ====
/* MPA single-cycle MIPS core top level
   Connects fetch, decode, register file and load unit, muxes debug read-out */
module mpa_mips_top (
    input  logic                   mem_debug_clk_gate,
    input  logic                   HW_RSTn,
    input  mpa_core_pkg::dbg_req_t dbg,
    output mpa_core_pkg::word_t    dout
);
    import mpa_core_pkg::*;
    import mips_isa_pkg::*;

    mips_instr_t instr;      // Current instruction
    ctrl_t       ctrl;
    word_t       im_rdata;   // IM read-back
    word_t       dm_rdata;   // DM read-back
    word_t       mr_rdata;   // Register read-back
    word_t       rs_data;
    word_t       wb_data;

    mpa_fetch u_fetch (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .dbg                (dbg),
        .instr              (instr),
        .im_rdata           (im_rdata)
    );

    mpa_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    mpa_regfile u_regfile (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .dbg                (dbg),
        .instr              (instr),
        .ctrl               (ctrl),
        .wb_data            (wb_data),
        .rs_data            (rs_data),
        .dbg_rdata          (mr_rdata)
    );

    mpa_load_unit u_load_unit (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .dbg                (dbg),
        .instr              (instr),
        .ctrl               (ctrl),
        .rs_data            (rs_data),
        .wb_data            (wb_data),
        .dm_rdata           (dm_rdata)
    );

    // Debug read-out, same cycle as func and addr
    always_comb begin
        case (dbg.func)
            dbg_im:  dout = im_rdata;
            dbg_dm:  dout = dm_rdata;
            dbg_mr:  dout = mr_rdata;
            default: dout = '0;  // dbg_none
        endcase
    end

endmodule

// ==== rtl/mpa_load_unit.sv ====
/* Load unit
   Address adder, data memory and write-back extension by load kind */
module mpa_load_unit (
    input  logic                      mem_debug_clk_gate,
    input  mpa_core_pkg::dbg_req_t    dbg,
    input  mips_isa_pkg::mips_instr_t instr,
    input  mips_isa_pkg::ctrl_t       ctrl,
    input  mpa_core_pkg::word_t       rs_data,
    output mpa_core_pkg::word_t       wb_data,
    output mpa_core_pkg::word_t       dm_rdata
);
    import mpa_core_pkg::*;
    import mips_isa_pkg::*;

    localparam int dm_aw = $clog2(dm_depth);  // Word index width

    word_t            dm_mem [dm_depth];  // No reset
    word_t            imm_sext;
    word_t            eff_addr;
    logic [dm_aw-1:0] dm_idx;
    logic             dm_we;

    // Base plus sign-extended offset
    assign imm_sext = {{(data_width-imm_w){instr.imm[imm_w-1]}}, instr.imm};
    assign eff_addr = rs_data + imm_sext;

    // Word aligned, byte offset dropped
    assign dm_idx = dbg.mem_debug ? dbg.addr[dm_aw+1:2] : eff_addr[dm_aw+1:2];
    assign dm_we  = dbg.mem_debug && dbg.we && (dbg.func == dbg_dm);

    assign dm_rdata = dm_mem[dm_idx];  // Combinational read

    // Only the back-door writes, stores are not executed
    always_ff @(posedge mem_debug_clk_gate) begin
        if (dm_we) begin
            dm_mem[dm_idx] <= dbg.din;
        end
    end

    // Write-back formatting
    always_comb begin
        case (ctrl.load_kind)
            ld_upper_imm: wb_data = {instr.imm, {(data_width-imm_w){1'b0}}};
            ld_byte: begin
                wb_data = {{(data_width-8){dm_rdata[7]}}, dm_rdata[7:0]};
            end
            ld_byte_u: begin
                wb_data = {{(data_width-8){1'b0}}, dm_rdata[7:0]};
            end
            ld_half: begin
                wb_data = {{(data_width-16){dm_rdata[15]}}, dm_rdata[15:0]};
            end
            ld_half_u: begin
                wb_data = {{(data_width-16){1'b0}}, dm_rdata[15:0]};
            end
            ld_word:   wb_data = dm_rdata;
            default:   wb_data = '0;  // ld_none, not written anyway
        endcase
    end

endmodule

// ==== rtl/mpa_regfile.sv ====
/* MIPS register file
   32 GPRs, r0 tied to zero, with back-door read and write */
module mpa_regfile (
    input  logic                      mem_debug_clk_gate,
    input  logic                      HW_RSTn,
    input  mpa_core_pkg::dbg_req_t    dbg,
    input  mips_isa_pkg::mips_instr_t instr,
    input  mips_isa_pkg::ctrl_t       ctrl,
    input  mpa_core_pkg::word_t       wb_data,
    output mpa_core_pkg::word_t       rs_data,
    output mpa_core_pkg::word_t       dbg_rdata
);
    import mpa_core_pkg::*;
    import mips_isa_pkg::*;

    word_t                regs [num_regs];
    logic [reg_idx_w-1:0] dbg_idx;
    logic [reg_idx_w-1:0] wr_idx;
    word_t                wr_data;
    logic                 wr_en;

    assign dbg_idx = dbg.addr[reg_idx_w-1:0];  // Register index from low bits

    // Write port owner, program writes blocked in debug
    always_comb begin
        if (dbg.mem_debug) begin
            wr_en   = dbg.we && (dbg.func == dbg_mr);
            wr_idx  = dbg_idx;
            wr_data = dbg.din;
        end else begin
            wr_en   = ctrl.reg_we;
            wr_idx  = instr.rt;  // I-type destination
            wr_data = wb_data;
        end
    end

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin  // r0 never written
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs_data   = regs[instr.rs];  // Load base
    assign dbg_rdata = regs[dbg_idx];

endmodule

// ==== rtl/mpa_decoder.sv ====
/* Instruction decoder
   Turns the primary opcode into write enable and load kind */
module mpa_decoder (
    input  mips_isa_pkg::mips_instr_t instr,
    output mips_isa_pkg::ctrl_t       ctrl
);
    import mips_isa_pkg::*;

    // Only LUI and the five loads write back
    always_comb begin
        case (instr.opcode)
            op_lui: begin
                ctrl.reg_we    = 1'b1;
                ctrl.load_kind = ld_upper_imm;
            end
            op_lb: begin
                ctrl.reg_we    = 1'b1;
                ctrl.load_kind = ld_byte;
            end
            op_lbu: begin
                ctrl.reg_we    = 1'b1;
                ctrl.load_kind = ld_byte_u;
            end
            op_lh: begin
                ctrl.reg_we    = 1'b1;
                ctrl.load_kind = ld_half;
            end
            op_lhu: begin
                ctrl.reg_we    = 1'b1;
                ctrl.load_kind = ld_half_u;
            end
            op_lw: begin
                ctrl.reg_we    = 1'b1;
                ctrl.load_kind = ld_word;
            end
            default: begin
                // R-type, stores, branches and immediate ALU ops run as no-ops
                ctrl.reg_we    = 1'b0;
                ctrl.load_kind = ld_none;
            end
        endcase
    end

endmodule

// ==== rtl/mpa_fetch.sv ====
/* Fetch stage
   Program counter and instruction memory with back-door write */
module mpa_fetch (
    input  logic                      mem_debug_clk_gate,
    input  logic                      HW_RSTn,
    input  mpa_core_pkg::dbg_req_t    dbg,
    output mips_isa_pkg::mips_instr_t instr,
    output mpa_core_pkg::word_t       im_rdata
);
    import mpa_core_pkg::*;

    localparam int im_aw = $clog2(im_depth);  // Word index width

    word_t            pc;
    word_t            pc_next;
    word_t            im_mem [im_depth];  // No reset, loaded over the back-door
    logic [im_aw-1:0] im_idx;
    logic             im_we;

    // Back-door takes the address while debug is active
    assign im_idx = dbg.mem_debug ? dbg.addr[im_aw+1:2] : pc[im_aw+1:2];
    assign im_we  = dbg.mem_debug && dbg.we && (dbg.func == dbg_im);

    // Asynchronous read, one instruction per cycle
    assign im_rdata = im_mem[im_idx];
    assign instr    = im_rdata;  // Word reinterpreted as I-type fields

    // Next PC stays inside the IM window
    assign pc_next = {{(data_width-im_aw-2){1'b0}}, pc[im_aw+1:2] + 1'b1, 2'b00};

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc <= reset_pc;
        end else if (dbg.mem_debug) begin
            pc <= reset_pc;  // Restart from the top after debug
        end else begin
            pc <= pc_next;
        end
    end

    // Debug write port
    always_ff @(posedge mem_debug_clk_gate) begin
        if (im_we) begin
            im_mem[im_idx] <= dbg.din;
        end
    end

endmodule

// ==== rtl/mips_isa_pkg.sv ====
/* MIPS ISA package
   Opcodes, load kinds, I-type field layout and decoder control bundle */
package mips_isa_pkg;

    // Field widths of the I-type format
    localparam int opcode_w  = 6;
    localparam int reg_idx_w = 5;
    localparam int imm_w     = 16;

    localparam int num_regs = 2 ** reg_idx_w;  // 32 GPRs

    // Primary opcodes that the core recognises
    typedef enum logic [opcode_w-1:0] {
        op_special = 6'b00_0000,  // R-type, executes as no-op
        op_lui     = 6'b00_1111,
        op_lb      = 6'b10_0000,
        op_lh      = 6'b10_0001,
        op_lw      = 6'b10_0011,
        op_lbu     = 6'b10_0100,
        op_lhu     = 6'b10_0101
    } opcode_e;

    // Selects how write-back data is built
    typedef enum logic [2:0] {
        ld_none,       // No write-back
        ld_upper_imm,  // LUI
        ld_byte,       // Low byte, sign-extended
        ld_byte_u,     // Low byte, zero-extended
        ld_half,       // Low halfword, sign-extended
        ld_half_u,     // Low halfword, zero-extended
        ld_word        // Full word
    } load_kind_e;

    // I-type layout, opcode in bits 31:26
    typedef struct packed {
        opcode_e              opcode;
        logic [reg_idx_w-1:0] rs;   // Base register
        logic [reg_idx_w-1:0] rt;   // Destination register
        logic [imm_w-1:0]     imm;  // Offset or LUI value
    } mips_instr_t;

    typedef struct packed {
        logic       reg_we;     // Write rt at the next edge
        load_kind_e load_kind;
    } ctrl_t;

endpackage

// ==== rtl/mpa_core_pkg.sv ====
/* MPA core package
   Machine widths, memory depths and the debug back-door request type */
package mpa_core_pkg;

    // Word size for data and instructions
    localparam int data_width = 32;

    // Memory capacity in words
    localparam int im_depth = 32;
    localparam int dm_depth = 32;

    // PC after reset and while in debug
    localparam logic [data_width-1:0] reset_pc = '0;

    typedef logic [data_width-1:0] word_t;

    // Back-door target select
    typedef enum logic [1:0] {
        dbg_none = 2'd0,  // Nothing selected, dout reads zero
        dbg_im   = 2'd1,  // Instruction memory
        dbg_dm   = 2'd2,  // Data memory
        dbg_mr   = 2'd3   // MIPS register file
    } debug_func_e;

    // Debug request bundle, 68 bits
    // IM and DM take a byte address with bits 1:0 ignored
    // MR takes the register index from addr[4:0]
    typedef struct packed {
        logic        mem_debug;  // Back-door owns the core
        debug_func_e func;       // Target
        logic        we;         // Write strobe
        word_t       addr;       // Byte address or register index
        word_t       din;        // Write data
    } dbg_req_t;

endpackage
